//--- design/rvCorePkg.sv
package rvCorePkg;

   // Architectural widths of the RV32I datapath
   localparam int XLEN = 32;
   localparam int REG_ADDR_BITS = 5;
   localparam int BYTE_BITS = 8;

   // One data or address word
   typedef logic [XLEN-1:0] wordT;

   // Index into the integer register file
   typedef logic [REG_ADDR_BITS-1:0] regAddrT;

   // One byte lane of a word
   typedef logic [BYTE_BITS-1:0] byteT;

   // Writeback value select
   typedef enum logic [1:0] {
      RESULT_ALU,
      RESULT_MEM,
      RESULT_PC4
   } resultSrcT;

endpackage

//--- design/memBusPkg.sv
package memBusPkg;

   // Data RAM size and the word address derived from a byte address
   localparam int MEM_WORDS = 256;
   localparam int MEM_ADDR_BITS = $clog2(MEM_WORDS);
   localparam int WORD_OFFSET_BITS = 2;

   typedef logic [MEM_ADDR_BITS-1:0] memAddrT;
   typedef logic [WORD_OFFSET_BITS-1:0] byteLaneT;

   // APB master phases
   typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apbStateT;

endpackage

//--- design/memoryStage.sv
`timescale 1ns/1ps

module memoryStage (
   input  logic                clk,
   input  logic                rst,
   input  logic                validM,
   input  logic                regWriteM,
   input  logic                memWriteM,
   input  logic                memReadM,
   input  logic                loadByteM,
   input  rvCorePkg::wordT     aluResultM,
   input  rvCorePkg::wordT     writeDataM,
   input  rvCorePkg::wordT     pcPlus4M,
   input  rvCorePkg::regAddrT  rdM,
   input  rvCorePkg::resultSrcT resultSrcM,
   output logic                stall,
   output logic                psel,
   output logic                penable,
   output logic                pwrite,
   output memBusPkg::memAddrT  paddr,
   output rvCorePkg::wordT     pwdata,
   input  rvCorePkg::wordT     prdata,
   input  logic                pready,
   output rvCorePkg::wordT     aluResultW,
   output rvCorePkg::wordT     readDataW,
   output rvCorePkg::wordT     pcPlus4W,
   output rvCorePkg::regAddrT  rdW,
   output logic                regWriteW,
   output rvCorePkg::resultSrcT resultSrcW,
   output rvCorePkg::regAddrT  rdMH,
   output logic                regWriteMH
);

   memBusPkg::apbStateT state;
   memBusPkg::apbStateT stateNext;
   memBusPkg::byteLaneT lane;
   rvCorePkg::byteT     loadByte;
   rvCorePkg::wordT     loadData;
   logic                memAccess;
   logic                accept;

   assign memAccess = validM & (memReadM | memWriteM);

   // Master sequence IDLE -> SETUP -> ACCESS until pready
   always_comb begin
      stateNext = state;
      unique case (state)
         memBusPkg::IDLE:   if (memAccess) stateNext = memBusPkg::SETUP;
         memBusPkg::SETUP:  stateNext = memBusPkg::ACCESS;
         memBusPkg::ACCESS: if (pready) stateNext = memBusPkg::IDLE;
         default:           stateNext = memBusPkg::IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= memBusPkg::IDLE;
      end else begin
         state <= stateNext;
      end
   end

   // Held high from the first sight of a memory op until the completing cycle
   assign stall = (state == memBusPkg::IDLE) ? memAccess :
                  !((state == memBusPkg::ACCESS) && pready);
   assign accept = validM & ~stall;

   // Upstream holds its inputs during stall, so the bus fields stay stable
   assign psel    = (state != memBusPkg::IDLE);
   assign penable = (state == memBusPkg::ACCESS);
   assign pwrite  = psel & memWriteM;
   assign paddr   = aluResultM[memBusPkg::WORD_OFFSET_BITS +: memBusPkg::MEM_ADDR_BITS];
   assign pwdata  = writeDataM;

   // Byte loads take one lane and zero-extend it
   assign lane     = aluResultM[memBusPkg::WORD_OFFSET_BITS-1:0];
   assign loadByte = prdata[lane*rvCorePkg::BYTE_BITS +: rvCorePkg::BYTE_BITS];
   assign loadData = loadByteM ? rvCorePkg::wordT'(loadByte) : prdata;

   // M-to-W register, bubble when nothing is accepted
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         aluResultW <= '0;
         readDataW  <= '0;
         pcPlus4W   <= '0;
         rdW        <= '0;
         regWriteW  <= 1'b0;
         resultSrcW <= rvCorePkg::RESULT_ALU;
      end else if (accept) begin
         aluResultW <= aluResultM;
         readDataW  <= loadData;
         pcPlus4W   <= pcPlus4M;
         rdW        <= rdM;
         regWriteW  <= regWriteM;
         resultSrcW <= resultSrcM;
      end else begin
         regWriteW  <= 1'b0;
      end
   end

   // Hazard unit sees the M-stage destination directly
   assign rdMH       = rdM;
   assign regWriteMH = regWriteM;

endmodule

//--- design/dataMemory.sv
`timescale 1ns/1ps

module dataMemory #(
   parameter int waitStates = 3
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  memBusPkg::memAddrT paddr,
   input  rvCorePkg::wordT    pwdata,
   output rvCorePkg::wordT    prdata,
   output logic               pready
);

   localparam int CNT_BITS = $clog2(waitStates + 2);

   rvCorePkg::wordT     mem [memBusPkg::MEM_WORDS];
   logic [CNT_BITS-1:0] waitCnt;
   logic                accessPhase;

   assign accessPhase = psel & penable;

   // Counts ACCESS cycles until the programmed wait is used up
   assign pready = accessPhase && (waitCnt == CNT_BITS'(waitStates));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         waitCnt <= '0;
      end else if (accessPhase && !pready) begin
         waitCnt <= waitCnt + 1'b1;
      end else begin
         waitCnt <= '0;
      end
   end

   // Store lands on the completing edge
   always_ff @(posedge clk) begin
      if (accessPhase && pwrite && pready) begin
         mem[paddr] <= pwdata;
      end
   end

   // Read data valid whenever pready is high
   assign prdata = mem[paddr];

endmodule

//--- design/writebackStage.sv
`timescale 1ns/1ps

module writebackStage (
   input  rvCorePkg::wordT      aluResultW,
   input  rvCorePkg::wordT      readDataW,
   input  rvCorePkg::wordT      pcPlus4W,
   input  rvCorePkg::resultSrcT resultSrcW,
   input  logic                 regWriteW,
   input  rvCorePkg::regAddrT   rdW,
   output rvCorePkg::wordT      resultW,
   output logic                 weW,
   output rvCorePkg::regAddrT   waddr
);

   // Result mux
   always_comb begin
      unique case (resultSrcW)
         rvCorePkg::RESULT_ALU: resultW = aluResultW;
         rvCorePkg::RESULT_MEM: resultW = readDataW;
         rvCorePkg::RESULT_PC4: resultW = pcPlus4W;
         default:               resultW = aluResultW;
      endcase
   end

   // x0 is never written
   assign weW   = regWriteW && (rdW != '0);
   assign waddr = rdW;

endmodule

//--- design/registerFile.sv
`timescale 1ns/1ps

module registerFile (
   input  logic               clk,
   input  logic               rst,
   input  logic               we,
   input  rvCorePkg::regAddrT waddr,
   input  rvCorePkg::wordT    wdata,
   input  rvCorePkg::regAddrT raddr1,
   input  rvCorePkg::regAddrT raddr2,
   output rvCorePkg::wordT    rdata1,
   output rvCorePkg::wordT    rdata2
);

   // Storage for x1..x31 only
   rvCorePkg::wordT regs [31:1];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (waddr != '0)) begin
         regs[waddr] <= wdata;
      end
   end

   // Two combinational read ports, x0 reads zero
   assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
   assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- design/memWbTop.sv
`timescale 1ns/1ps

module memWbTop #(
   parameter int waitStates = 3
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 validM,
   input  rvCorePkg::wordT      aluResultM,
   input  rvCorePkg::wordT      writeDataM,
   input  rvCorePkg::wordT      pcPlus4M,
   input  rvCorePkg::regAddrT   rdM,
   input  logic                 regWriteM,
   input  logic                 memWriteM,
   input  logic                 memReadM,
   input  rvCorePkg::resultSrcT resultSrcM,
   input  logic                 loadByteM,
   output logic                 stall,
   output rvCorePkg::regAddrT   rdMH,
   output logic                 regWriteMH,
   output rvCorePkg::regAddrT   rdW,
   output logic                 regWriteW,
   output rvCorePkg::wordT      resultW,
   input  rvCorePkg::regAddrT   dbgAddr1,
   input  rvCorePkg::regAddrT   dbgAddr2,
   output rvCorePkg::wordT      dbgData1,
   output rvCorePkg::wordT      dbgData2
);

   // APB between the M stage and the data RAM
   logic               psel;
   logic               penable;
   logic               pwrite;
   logic               pready;
   memBusPkg::memAddrT paddr;
   rvCorePkg::wordT    pwdata;
   rvCorePkg::wordT    prdata;

   // W register contents
   rvCorePkg::wordT      aluResultW;
   rvCorePkg::wordT      readDataW;
   rvCorePkg::wordT      pcPlus4W;
   rvCorePkg::resultSrcT resultSrcW;

   // Register file write port
   logic               weW;
   rvCorePkg::regAddrT waddr;

   memoryStage memoryStage_inst (
      .clk(clk), .rst(rst),
      .validM(validM), .regWriteM(regWriteM), .memWriteM(memWriteM),
      .memReadM(memReadM), .loadByteM(loadByteM),
      .aluResultM(aluResultM), .writeDataM(writeDataM), .pcPlus4M(pcPlus4M),
      .rdM(rdM), .resultSrcM(resultSrcM), .stall(stall),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
      .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .aluResultW(aluResultW), .readDataW(readDataW), .pcPlus4W(pcPlus4W),
      .rdW(rdW), .regWriteW(regWriteW), .resultSrcW(resultSrcW),
      .rdMH(rdMH), .regWriteMH(regWriteMH)
   );

   dataMemory #(.waitStates(waitStates)) dataMemory_inst (
      .clk(clk), .rst(rst),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
      .pwdata(pwdata), .prdata(prdata), .pready(pready)
   );

   writebackStage writebackStage_inst (
      .aluResultW(aluResultW), .readDataW(readDataW), .pcPlus4W(pcPlus4W),
      .resultSrcW(resultSrcW), .regWriteW(regWriteW), .rdW(rdW),
      .resultW(resultW), .weW(weW), .waddr(waddr)
   );

   // Port 2 is the main debug read, port 1 a second observation point
   registerFile registerFile_inst (
      .clk(clk), .rst(rst),
      .we(weW), .waddr(waddr), .wdata(resultW),
      .raddr1(dbgAddr1), .raddr2(dbgAddr2),
      .rdata1(dbgData1), .rdata2(dbgData2)
   );

endmodule

//--- tests/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
   parameter int period = 40
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

endmodule

//--- tests/memWb_checker.sv
`timescale 1ns/1ps

module memWb_checker (
   input logic                clk,
   input logic                rst,
   input memBusPkg::apbStateT state,
   input logic                psel,
   input logic                penable,
   input logic                pwrite,
   input memBusPkg::memAddrT  paddr,
   input logic                pready,
   input logic                stall
);

   // Failure count watched by the testbench
   int failCount;

   initial failCount = 0;

   // SETUP is one cycle with penable low, then ACCESS
   setupThenAccess: assert property (@(posedge clk) disable iff (rst)
      state == memBusPkg::SETUP |-> psel && !penable ##1 state == memBusPkg::ACCESS)
      else begin
         $error("APB SETUP phase not followed by ACCESS");
         failCount++;
      end

   busStable: assert property (@(posedge clk) disable iff (rst)
      psel && !pready |=> $stable(paddr) && $stable(pwrite))
      else begin
         $error("APB address or direction changed during a transfer");
         failCount++;
      end

   // Only the completing ACCESS cycle releases the pipeline
   stallWhileBusy: assert property (@(posedge clk) disable iff (rst)
      state != memBusPkg::IDLE && !(penable && pready) |-> stall)
      else begin
         $error("stall low while an APB transfer is in flight");
         failCount++;
      end

endmodule

bind memoryStage memWb_checker memWb_checker_inst (
   .clk(clk), .rst(rst), .state(state), .psel(psel), .penable(penable),
   .pwrite(pwrite), .paddr(paddr), .pready(pready), .stall(stall)
);

//--- tests/memWbTb.sv
`timescale 1ns/1ps

module memWbTb;

   localparam int CLK_PERIOD = 40;
   localparam int WAIT_STATES = 3;
   localparam int ALU_COUNT = 12;
   localparam int MEM_COUNT = 6;
   // Instructions plus six register sweeps of 33 cycles
   localparam int TEST_OPS = ALU_COUNT + 2 * MEM_COUNT + 12 + 6 * 33;
   localparam int LIMIT_CYCLES = TEST_OPS * (WAIT_STATES + 4) + 100;

   logic clk;
   logic rst;
   logic validM, regWriteM, memWriteM, memReadM, loadByteM;
   logic stall, regWriteMH, regWriteW;
   rvCorePkg::wordT aluResultM, writeDataM, pcPlus4M, resultW, dbgData1, dbgData2;
   rvCorePkg::regAddrT rdM, rdMH, rdW, dbgAddr1, dbgAddr2;
   rvCorePkg::resultSrcT resultSrcM;
   rvCorePkg::wordT regMirror [32];
   rvCorePkg::wordT memMirror [memBusPkg::MEM_WORDS];
   logic [15:0] lfsr;

   tbClock #(.period(CLK_PERIOD)) tbClock_inst (.clk(clk));

   memWbTop #(.waitStates(WAIT_STATES)) memWbTop_inst (.*);

   // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1
   function automatic rvCorePkg::wordT randBits(input int n);
      rvCorePkg::wordT v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr[15]};
         lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      end
      return v;
   endfunction

   function automatic rvCorePkg::regAddrT randReg();
      rvCorePkg::regAddrT r;
      r = rvCorePkg::regAddrT'(randBits(5));
      return (r == '0) ? 5'd1 : r;
   endfunction

   task automatic failRun(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic checkValue(input string name, input rvCorePkg::wordT exp,
                             input rvCorePkg::wordT act);
      assert (act === exp) else begin
         failRun($sformatf("error: %s expected 0x%h, got 0x%h", name, exp, act));
      end
   endtask

   task automatic clearInputs();
      validM = 1'b0;
      regWriteM = 1'b0;
      memWriteM = 1'b0;
      memReadM = 1'b0;
      loadByteM = 1'b0;
      resultSrcM = rvCorePkg::RESULT_ALU;
   endtask

   // Pipeline drains one cycle with nothing presented
   task automatic idle();
      clearInputs();
      @(posedge clk);
      #2;
   endtask

   task automatic present(input logic rdMem, input logic wrMem, input logic byteLd,
                          input logic wrReg, input rvCorePkg::resultSrcT src,
                          input rvCorePkg::wordT alu, input rvCorePkg::wordT data,
                          input rvCorePkg::wordT pc, input rvCorePkg::regAddrT rd);
      validM = 1'b1;
      memReadM = rdMem;
      memWriteM = wrMem;
      loadByteM = byteLd;
      regWriteM = wrReg;
      resultSrcM = src;
      aluResultM = alu;
      writeDataM = data;
      pcPlus4M = pc;
      rdM = rd;
   endtask

   // Returns just after the edge that accepts the presented instruction
   task automatic waitAccept(output int stallCycles);
      logic held;
      stallCycles = 0;
      do begin
         @(negedge clk);
         held = stall;
         checkValue("rdMH", rvCorePkg::wordT'(rdM), rvCorePkg::wordT'(rdMH));
         checkValue("regWriteMH", rvCorePkg::wordT'(regWriteM),
                    rvCorePkg::wordT'(regWriteMH));
         if (held) stallCycles++;
         @(posedge clk);
      end while (held);
      #2;
   endtask

   task automatic checkRegs();
      for (int i = 0; i < 32; i++) begin
         dbgAddr1 = rvCorePkg::regAddrT'(i);
         dbgAddr2 = rvCorePkg::regAddrT'(i);
         @(negedge clk);
         checkValue($sformatf("dbgData1 x%0d", i), regMirror[i], dbgData1);
         checkValue($sformatf("dbgData2 x%0d", i), regMirror[i], dbgData2);
         @(posedge clk);
         #2;
      end
   endtask

   task automatic storeWord(input rvCorePkg::wordT addr, input rvCorePkg::wordT data);
      int stalls;
      present(1'b0, 1'b1, 1'b0, 1'b0, rvCorePkg::RESULT_ALU, addr, data, 0, '0);
      waitAccept(stalls);
      assert (stalls >= WAIT_STATES + 1) else failRun("a store did not wait for the memory");
      memMirror[addr[9:2]] = data;
   endtask

   task automatic loadWord(input rvCorePkg::wordT addr, input rvCorePkg::regAddrT rd,
                           input logic byteLd);
      rvCorePkg::wordT expected;
      int stalls;
      expected = memMirror[addr[9:2]];
      if (byteLd) expected = (expected >> (8 * addr[1:0])) & 32'hff;
      present(1'b1, 1'b0, byteLd, 1'b1, rvCorePkg::RESULT_MEM, addr, 0, 0, rd);
      waitAccept(stalls);
      assert (stalls >= WAIT_STATES + 1) else failRun("a load did not wait for the memory");
      checkValue("resultW", expected, resultW);
      regMirror[rd] = expected;
   endtask

   task automatic resetTest();
      @(negedge clk);
      checkValue("stall", 0, rvCorePkg::wordT'(stall));
      checkValue("regWriteW", 0, rvCorePkg::wordT'(regWriteW));
      @(posedge clk);
      #2;
      checkRegs();
   endtask

   task automatic aluTest();
      rvCorePkg::regAddrT rd;
      rvCorePkg::wordT value;
      int stalls;
      for (int k = 0; k < ALU_COUNT; k++) begin
         // One write aimed at x0
         rd = (k == 3) ? 5'd0 : rvCorePkg::regAddrT'(randBits(5));
         value = randBits(32);
         present(1'b0, 1'b0, 1'b0, 1'b1, rvCorePkg::RESULT_ALU, value, 0, 0, rd);
         waitAccept(stalls);
         assert (stalls == 0) else failRun("an ALU instruction was stalled");
         checkValue("resultW", value, resultW);
         checkValue("rdW", rvCorePkg::wordT'(rd), rvCorePkg::wordT'(rdW));
         checkValue("regWriteW", 1, rvCorePkg::wordT'(regWriteW));
         if (rd != '0) regMirror[rd] = value;
      end
      idle();
      checkRegs();
   endtask

   task automatic memTest();
      rvCorePkg::wordT addrs [MEM_COUNT];
      for (int k = 0; k < MEM_COUNT; k++) begin
         addrs[k] = randBits(8) << 2;
         storeWord(addrs[k], randBits(32));
      end
      // Reverse order, repeated addresses return the last store
      for (int k = MEM_COUNT - 1; k >= 0; k--) begin
         loadWord(addrs[k], randReg(), 1'b0);
      end
      idle();
      checkRegs();
   endtask

   task automatic byteTest();
      rvCorePkg::wordT base;
      base = randBits(8) << 2;
      storeWord(base, randBits(32));
      for (int lane = 0; lane < 4; lane++) begin
         loadWord(base + lane, randReg(), 1'b1);
      end
      idle();
      checkRegs();
   endtask

   task automatic pcTest();
      rvCorePkg::regAddrT rd;
      rvCorePkg::wordT pc;
      int stalls;
      rd = randReg();
      pc = randBits(30) << 2;
      present(1'b0, 1'b0, 1'b0, 1'b1, rvCorePkg::RESULT_PC4, randBits(32), 0, pc, rd);
      waitAccept(stalls);
      checkValue("resultW", pc, resultW);
      regMirror[rd] = pc;
      idle();
      checkRegs();
   endtask

   // ALU result retires while the following load still holds the stall
   task automatic overlapTest();
      rvCorePkg::regAddrT aluRd;
      rvCorePkg::regAddrT loadRd;
      rvCorePkg::wordT value;
      rvCorePkg::wordT addr;
      int stalls;
      aluRd = randReg();
      loadRd = aluRd + 5'd1;
      if (loadRd == '0) loadRd = 5'd1;
      value = randBits(32);
      addr = randBits(8) << 2;
      storeWord(addr, randBits(32));
      present(1'b0, 1'b0, 1'b0, 1'b1, rvCorePkg::RESULT_ALU, value, 0, 0, aluRd);
      waitAccept(stalls);
      present(1'b1, 1'b0, 1'b0, 1'b1, rvCorePkg::RESULT_MEM, addr, 0, 0, loadRd);
      @(posedge clk);
      #2;
      dbgAddr1 = aluRd;
      dbgAddr2 = loadRd;
      @(negedge clk);
      assert (stall) else failRun("stall dropped before the load completed");
      // W register holds a bubble while the load waits
      checkValue("regWriteW", 0, rvCorePkg::wordT'(regWriteW));
      checkValue("dbgData1", value, dbgData1);
      checkValue("dbgData2", regMirror[loadRd], dbgData2);
      regMirror[aluRd] = value;
      @(posedge clk);
      #2;
      waitAccept(stalls);
      checkValue("resultW", memMirror[addr[9:2]], resultW);
      regMirror[loadRd] = memMirror[addr[9:2]];
      idle();
      checkRegs();
   endtask

   initial begin
      #(LIMIT_CYCLES * CLK_PERIOD);
      failRun("timeout: the tests did not finish in the allowed time");
   end

   // Bound checker failures end the run at once
   always @(memWbTop_inst.memoryStage_inst.memWb_checker_inst.failCount) begin
      if (memWbTop_inst.memoryStage_inst.memWb_checker_inst.failCount != 0) begin
         failRun("a bus protocol assertion failed");
      end
   end

   initial begin
      lfsr = 16'd38;
      rst = 1'b1;
      clearInputs();
      aluResultM = '0;
      writeDataM = '0;
      pcPlus4M = '0;
      rdM = '0;
      dbgAddr1 = '0;
      dbgAddr2 = '0;
      foreach (regMirror[i]) regMirror[i] = '0;
      repeat (4) @(posedge clk);
      #2;
      rst = 1'b0;
      resetTest();
      aluTest();
      memTest();
      byteTest();
      pcTest();
      overlapTest();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

//--- filelist.f
design/rvCorePkg.sv
design/memBusPkg.sv
design/memoryStage.sv
design/dataMemory.sv
design/writebackStage.sv
design/registerFile.sv
design/memWbTop.sv
tests/tbClock.sv
tests/memWb_checker.sv
tests/memWbTb.sv

//--- Bender.yml
package:
  name: mem_wb_backend

sources:
  - files:
      - design/rvCorePkg.sv
      - design/memBusPkg.sv
      - design/memoryStage.sv
      - design/dataMemory.sv
      - design/writebackStage.sv
      - design/registerFile.sv
      - design/memWbTop.sv
  - target: test
    files:
      - tests/tbClock.sv
      - tests/memWb_checker.sv
      - tests/memWbTb.sv
